/* bch_macros.svh */
`ifndef BCH_MACROS_SVH
`define BCH_MACROS_SVH

// Code length in bits.
`define BCH_N 15

// Message bits per codeword.
`define BCH_K 5

// Errors corrected per codeword.
`define BCH_T 2

// Width of a GF(2^4) element.
`define BCH_M 4

// Low terms of x^4 + x + 1, the x^4 term is implied.
`define BCH_POLY 4'b0011

// Cycles from a bit on din to its decoded bit on dout.
`define BCH_LAT (`BCH_N + 2)

`endif

/* bch_pkg.sv */
`include "bch_macros.svh"

package bch_pkg;

	// Polynomial basis, bit i is the coefficient of x^i.
	typedef logic [`BCH_M-1:0] gf_elem_t;

	localparam gf_elem_t GF_ONE = gf_elem_t'(1);
	localparam gf_elem_t GF_ALPHA = gf_elem_t'(2);

	// Shift and add multiply, reduced by the primitive polynomial.
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t term;
		acc = '0;
		term = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				acc = acc ^ term;
			// Times x, folding the carry back in.
			term = {term[`BCH_M-2:0], 1'b0} ^ (term[`BCH_M-1] ? `BCH_POLY : '0);
		end
		return acc;
	endfunction

	// Alpha raised to e, with the exponent taken modulo the group order.
	function automatic gf_elem_t gf_pow(input int e);
		gf_elem_t r;
		int steps;
		r = GF_ONE;
		steps = e % `BCH_N;
		for (int i = 0; i < `BCH_N; i++) begin
			if (i < steps)
				r = gf_mul(r, GF_ALPHA);
		end
		return r;
	endfunction

	// The frame counter starts at one and steps by alpha, so position idx
	// of a frame shows up as alpha^idx.
	function automatic gf_elem_t count_at(input int idx);
		return gf_pow(idx);
	endfunction

endpackage

/* frame_counter.sv */
`timescale 1ns/1ns
`include "bch_macros.svh"

module frame_counter import bch_pkg::*; (
	input logic clk,
	input logic reset,
	output gf_elem_t count
);

	localparam gf_elem_t START = count_at(0);

	gf_elem_t next_count;

	// Galois LFSR on x^4 + x + 1, period 15.
	assign next_count = {count[`BCH_M-2:0], 1'b0} ^
		(count[`BCH_M-1] ? `BCH_POLY : '0);

	always_ff @(posedge clk) begin
		if (reset)
			count <= START;
		else
			count <= next_count;
	end

endmodule

/* bch_syndrome.sv */
`timescale 1ns/1ns
`include "bch_macros.svh"

module bch_syndrome import bch_pkg::*; #(
	parameter int POWER = 1
) (
	input logic clk,
	input logic frame_end,
	input logic din,
	output gf_elem_t syn
);

	localparam gf_elem_t STEP = gf_pow(POWER);

	gf_elem_t din_elem;
	gf_elem_t acc;
	gf_elem_t acc_next;

	assign din_elem = {{(`BCH_M-1){1'b0}}, din};

	// Horner step, first bit ends up with the highest power.
	assign acc_next = gf_mul(acc, STEP) ^ din_elem;

	always_ff @(posedge clk) begin
		// New frame starts from its first bit alone.
		if (frame_end)
			acc <= din_elem;
		else
			acc <= acc_next;
	end

	// Full r(alpha^POWER) sits in acc on the frame_end cycle.
	assign syn = acc;

endmodule

/* bch_chien.sv */
`timescale 1ns/1ns

module bch_chien import bch_pkg::*; #(
	parameter int POWER = 1
) (
	input logic clk,
	input logic frame_end,
	input logic err,
	input logic errcheck,
	input gf_elem_t syn,
	output gf_elem_t ch
);

	localparam gf_elem_t STEP = gf_pow(POWER);

	logic unflip;
	gf_elem_t base;
	gf_elem_t ch_next;

	// After a load ch holds the plain syndrome. From then on it holds the
	// syndrome seen from the current bit with that bit trial-flipped, so
	// an error there shows up as a drop in the error count.

	// Undo the trial flip unless the bit really was corrected.
	assign unflip = errcheck && !err;
	assign base = unflip ? (ch ^ GF_ONE) : ch;

	// Move one bit toward lower degree and flip the new bit.
	assign ch_next = gf_mul(base, STEP) ^ GF_ONE;

	always_ff @(posedge clk) begin
		if (frame_end)
			ch <= syn;
		else
			ch <= ch_next;
	end

endmodule

/* gf_cube.sv */
`timescale 1ns/1ns

module gf_cube import bch_pkg::*; (
	input gf_elem_t in,
	output gf_elem_t out
);

	gf_elem_t sq;
	logic [6:0] prod;

	// Squaring is linear in GF(2^4).
	assign sq[0] = in[0] ^ in[2];
	assign sq[1] = in[2];
	assign sq[2] = in[1] ^ in[3];
	assign sq[3] = in[3];

	// Unreduced product of in and its square.
	assign prod[0] = in[0] & sq[0];
	assign prod[1] = (in[0] & sq[1]) ^ (in[1] & sq[0]);
	assign prod[2] = (in[0] & sq[2]) ^ (in[1] & sq[1]) ^ (in[2] & sq[0]);
	assign prod[3] = (in[0] & sq[3]) ^ (in[1] & sq[2]) ^
		(in[2] & sq[1]) ^ (in[3] & sq[0]);
	assign prod[4] = (in[1] & sq[3]) ^ (in[2] & sq[2]) ^ (in[3] & sq[1]);
	assign prod[5] = (in[2] & sq[3]) ^ (in[3] & sq[2]);
	assign prod[6] = in[3] & sq[3];

	// Fold x^4 to x^6 back with x^4 = x + 1.
	assign out[0] = prod[0] ^ prod[4];
	assign out[1] = prod[1] ^ prod[4] ^ prod[5];
	assign out[2] = prod[2] ^ prod[5] ^ prod[6];
	assign out[3] = prod[3] ^ prod[6];

endmodule

/* bch_decode.sv */
`timescale 1ns/1ns
`include "bch_macros.svh"

module bch_decode import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic din,
	output logic vdout,
	output logic dout
);

	localparam gf_elem_t IDX_FRAME = count_at(0);
	localparam gf_elem_t IDX_CHIEN = count_at(1);
	localparam gf_elem_t IDX_STOP = count_at(`BCH_K);

	gf_elem_t count;
	logic frame_end;
	logic chien_first;
	logic valid_stop;
	logic din_masked;

	gf_elem_t [`BCH_T-1:0] syn;
	gf_elem_t [`BCH_T-1:0] ch;
	gf_elem_t ch1;
	gf_elem_t ch3;
	gf_elem_t cube;

	logic errcheck;
	logic neq;
	logic err1;
	logic err2;
	logic err;
	logic ff1;
	logic ff3;

	logic first_done;
	logic valid_int;
	logic [`BCH_LAT-1:0] buffer;

	frame_counter u_counter (
		.clk(clk),
		.reset(reset),
		.count(count)
	);

	assign frame_end = count == IDX_FRAME;
	assign chien_first = count == IDX_CHIEN;
	assign valid_stop = count == IDX_STOP;

	// Nothing from din reaches the datapath while in reset.
	assign din_masked = din && !reset;

	// One syndrome and one Chien register per odd power.
	for (genvar i = 0; i < `BCH_T; i++) begin : g_odd
		bch_syndrome #(
			.POWER(2 * i + 1)
		) u_syn (
			.clk(clk),
			.frame_end(frame_end),
			.din(din_masked),
			.syn(syn[i])
		);

		bch_chien #(
			.POWER(2 * i + 1)
		) u_chien (
			.clk(clk),
			.frame_end(frame_end),
			.err(err),
			.errcheck(errcheck),
			.syn(syn[i]),
			.ch(ch[i])
		);
	end

	assign ch1 = ch[0];
	assign ch3 = ch[1];

	gf_cube u_cube (
		.in(ch1),
		.out(cube)
	);

	// ff1 and ff3 classify the syndrome still to be corrected.
	// ff1 low means no error, ff3 low with ff1 high means one error,
	// both high mean two errors.
	assign neq = cube != ch3;

	// A flip that clears the single error.
	assign err1 = ff1 && !ff3 && !neq && (ch1 == '0);

	// A flip that leaves exactly one error.
	assign err2 = ff1 && ff3 && !neq && (ch1 != '0);

	assign err = err1 || err2;

	// The first Chien cycle only holds the plain syndrome.
	assign errcheck = !chien_first;

	always_ff @(posedge clk) begin
		if (reset) begin
			ff1 <= 1'b0;
			ff3 <= 1'b0;
		end else if (chien_first || err) begin
			ff1 <= |ch1;
			ff3 <= neq;
		end
	end

	// Raw bits wait here for their correction.
	always_ff @(posedge clk) begin
		buffer <= {buffer[`BCH_LAT-2:0], din_masked};
	end

	// No frame has a syndrome until the first one has fully arrived.
	always_ff @(posedge clk) begin
		if (reset) begin
			first_done <= 1'b0;
			valid_int <= 1'b0;
			vdout <= 1'b0;
		end else begin
			if (valid_stop)
				first_done <= 1'b1;

			if (valid_stop)
				valid_int <= 1'b0;
			else if (frame_end && first_done)
				valid_int <= 1'b1;

			vdout <= valid_int;
		end
	end

	// Oldest buffered bit lines up with the Chien test of the same position.
	assign dout = vdout && (buffer[`BCH_LAT-1] ^ err);

endmodule

/* bch_decode_props.sv */
`timescale 1ns/1ns
`include "bch_macros.svh"

module bch_decode_props (
	input logic clk,
	input logic reset,
	input logic vdout,
	input logic dout
);

	// Length of the current run of output strobes.
	int run_len;

	always_ff @(posedge clk) begin
		if (reset || !vdout)
			run_len <= 0;
		else
			run_len <= run_len + 1;
	end

	// At most one message worth of strobes in a row.
	a_strobe_run: assert property (@(posedge clk) disable iff (reset)
		run_len <= `BCH_K)
		else $error("vdout stayed high for more than %0d cycles", `BCH_K);

	a_dout_quiet: assert property (@(posedge clk) disable iff (reset)
		!vdout |-> !dout)
		else $error("dout high while vdout is low");

	// Output register clears on reset.
	a_reset_clears: assert property (@(posedge clk)
		reset |=> !vdout)
		else $error("vdout high in the cycle after reset");

endmodule

/* bch_decode_tb.sv */
`timescale 1ns/1ns
`include "bch_macros.svh"

module bch_decode_tb;

	// Generator x^10 + x^8 + x^5 + x^4 + x^2 + x + 1.
	localparam logic [`BCH_N-1:0] GEN = 15'h0537;

	// Test frames plus two flush frames per test and the final drain.
	localparam int FRAMES = 283;
	localparam int LIMIT = FRAMES * `BCH_N + 3 * `BCH_LAT + 200;

	logic clk = 1'b0;
	logic reset;
	logic din;
	logic vdout;
	logic dout;

	logic expected_q[$];
	int cycle_idx;
	int watchdog;
	int errors;
	int passes;
	int test_base;

	bch_decode i_dut (
		.clk(clk),
		.reset(reset),
		.din(din),
		.vdout(vdout),
		.dout(dout)
	);

	bind bch_decode bch_decode_props i_props (
		.clk(clk),
		.reset(reset),
		.vdout(vdout),
		.dout(dout)
	);

	always #10 clk = ~clk;

	// Systematic encoding with the message in the top bits.
	function automatic logic [`BCH_N-1:0] bch_encode(input logic [`BCH_K-1:0] msg);
		logic [`BCH_N-1:0] rem;
		rem = {msg, {(`BCH_N-`BCH_K){1'b0}}};
		for (int i = `BCH_N - 1; i >= `BCH_N - `BCH_K; i--) begin
			if (rem[i])
				rem = rem ^ (GEN << (i - (`BCH_N - `BCH_K)));
		end
		return {msg, rem[`BCH_N-`BCH_K-1:0]};
	endfunction

	// Message bits leave BCH_LAT cycles after they entered.
	function automatic logic strobe_at(input int k);
		if (k < `BCH_LAT)
			return 1'b0;
		return ((k - `BCH_LAT) % `BCH_N) < `BCH_K;
	endfunction

	function automatic logic [`BCH_K-1:0] random_msg();
		logic [31:0] r;
		r = $urandom;
		return r[`BCH_K-1:0];
	endfunction

	function automatic logic [`BCH_N-1:0] random_flips(input int count);
		logic [`BCH_N-1:0] mask;
		int pos;
		mask = '0;
		while ($countones(mask) < count) begin
			pos = $urandom_range(`BCH_N - 1, 0);
			mask[pos] = 1'b1;
		end
		return mask;
	endfunction

	task automatic check_bit(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t ns: dout is %b, expected %b", $time, got, exp);
			errors++;
		end else begin
			passes++;
		end
	endtask

	task automatic check_valid(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t ns: vdout is %b, expected %b", $time, got, exp);
			errors++;
		end else begin
			passes++;
		end
	endtask

	task automatic drive_bit(input logic b);
		din = b;
		@(posedge clk);
		#2;
	endtask

	task automatic send_frame(input logic [`BCH_K-1:0] msg, input logic [`BCH_N-1:0] flips);
		logic [`BCH_N-1:0] cw;
		cw = bch_encode(msg) ^ flips;
		for (int i = `BCH_K - 1; i >= 0; i--)
			expected_q.push_back(msg[i]);
		for (int i = `BCH_N - 1; i >= 0; i--)
			drive_bit(cw[i]);
	endtask

	// Two clean frames push the last message of a test out.
	task automatic flush_frames();
		send_frame('0, '0);
		send_frame('0, '0);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		din = 1'b0;
		@(posedge clk);
		#2;
		expected_q.delete();
		@(posedge clk);
		#2;
		reset = 1'b0;
	endtask

	task automatic report_test(input string name);
		$display("Test %s finished with %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	always @(posedge clk) begin
		if (reset)
			cycle_idx <= 0;
		else
			cycle_idx <= cycle_idx + 1;
	end

	always @(negedge clk) begin : compare
		logic exp_bit;
		check_valid(vdout, strobe_at(cycle_idx));
		if (vdout === 1'b1) begin
			if (expected_q.size() == 0) begin
				$display("Output strobe at %0t ns with no decoded bit pending", $time);
				errors++;
			end else begin
				exp_bit = expected_q.pop_front();
				check_bit(dout, exp_bit);
			end
		end else begin
			check_bit(dout, 1'b0);
		end
	end

	always @(posedge clk) begin
		watchdog <= watchdog + 1;
		if (watchdog >= LIMIT) begin
			$display("simulation timed out after %0d cycles", watchdog);
			$display("Errors found");
			$finish;
		end
	end

	initial begin : stimulus
		logic [`BCH_K-1:0] msg;
		void'($urandom(39));
		din = 1'b0;
		reset = 1'b1;
		cycle_idx = 0;
		watchdog = 0;
		errors = 0;
		passes = 0;
		test_base = 0;

		apply_reset();
		for (int f = 0; f < 3; f++)
			send_frame(random_msg(), '0);
		flush_frames();
		report_test("start-up strobe timing");

		for (int m = 0; m < 32; m++)
			send_frame(m[`BCH_K-1:0], '0);
		flush_frames();
		report_test("all clean messages");

		for (int pass = 0; pass < 2; pass++) begin
			for (int p = 0; p < `BCH_N; p++)
				send_frame(random_msg(), {{(`BCH_N-1){1'b0}}, 1'b1} << p);
		end
		flush_frames();
		report_test("single error per position");

		for (int f = 0; f < 200; f++)
			send_frame(random_msg(), random_flips(2));
		flush_frames();
		report_test("two random errors");

		send_frame(random_msg(), random_flips(1));
		send_frame(random_msg(), random_flips(2));
		// Cut the next frame short.
		for (int i = 0; i < 7; i++) begin
			msg = random_msg();
			drive_bit(msg[0]);
		end
		apply_reset();
		for (int f = 0; f < 4; f++)
			send_frame(random_msg(), random_flips($urandom_range(2, 0)));
		flush_frames();
		report_test("reset in mid-stream");

		while (expected_q.size() > 0)
			drive_bit(1'b0);

		$display("Checks passed: %0d, errors: %0d", passes, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* bch_decode.f */
+incdir+.
bch_pkg.sv
frame_counter.sv
bch_syndrome.sv
bch_chien.sv
gf_cube.sv
bch_decode.sv
bch_decode_props.sv
bch_decode_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS := --binary --timing --assert -j 0
TOP := bch_decode_tb
FILELIST := bch_decode.f
MDIR := obj_dir

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
SIM := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuild only when a source, header or the file list changes.
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

# Fails unless the run prints the pass line.
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(MDIR)
